// ==== flist.f ====
noc_pkg.sv
credit_fifo.sv
hamming_encode_stage.sv
hamming_correct_stage.sv
pe_core_top.sv
tb_checker.sv
tb_pe_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the pe_core testbench with Verilator, run it and judge the log

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_pe_core -f flist.f -o sim_pe_core \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_pe_core > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log

grep -q "Testbench failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation PASSED"

// ==== tb_pe_core.sv ====
`timescale 1ns/1ns

module tb_pe_core;

	import noc_pkg::*;

	localparam int num_words = 64;
	localparam int reset_cycles = 10;
	localparam int idle_cycles = 5;
	localparam int stall_cycles = 40;
	// About 20 cycles per word on each path, with room for reset and the idle window
	localparam int cycle_limit = num_words * 2 * 20 + 4 * reset_cycles;

	logic clk, reset, done;
	logic dg_valid, dg_credit, flit_out_valid, flit_out_credit;
	logic flit_in_valid, flit_in_credit, db_valid, db_corrected, db_credit;
	logic [word_w-1:0] dg_data, db_data;
	logic [flit_w-1:0] flit_out_data, flit_in_data;
	logic [flit_w-1:0] router_q [$];
	int seed, error_count, cycle_count;
	int dg_tokens, rx_tokens, router_owed, bucket_owed;
	int sent, delivered, replayed, stall_left;
	logic stall_done;

	always #2 clk = ~clk;

	pe_core_top DUT (.*);

	tb_checker u_checker (.*);

	// One cycle of the data generator, router and bucket models
	task automatic model_cycle();
		int rnd;
		int flip_pos;
		logic [flit_w-1:0] flit;
		rnd = $random(seed);
		dg_tokens += dg_credit;
		rx_tokens += flit_in_credit;
		if (flit_out_valid)
		begin
			router_q.push_back(flit_out_data);
			router_owed++;
		end
		if (db_valid)
		begin
			delivered++;
			bucket_owed++;
		end
		dg_valid = 1'b0;
		if (sent < num_words && dg_tokens > 0 && rnd[0])
		begin
			dg_valid = 1'b1;
			dg_data = word_w'($random(seed));
			dg_tokens--;
			sent++;
		end
		flit_out_credit = router_owed > 0 && rnd[1];
		router_owed -= flit_out_credit;
		flit_in_valid = 1'b0;
		if (router_q.size() > 0 && rx_tokens > 0 && rnd[2])
		begin
			// Flit k has codeword bit k mod 8 flipped, where 7 leaves it clean
			flit = router_q.pop_front();
			flip_pos = replayed % 8;
			if (flip_pos != 7)
				flit[addr_w + flip_pos] = ~flit[addr_w + flip_pos];
			flit_in_valid = 1'b1;
			flit_in_data = flit;
			rx_tokens--;
			replayed++;
		end
		// The bucket goes silent once, halfway through the run
		if (!stall_done && delivered >= num_words / 2)
		begin
			stall_left = stall_cycles;
			stall_done = 1'b1;
		end
		db_credit = stall_left == 0 && bucket_owed > 0 && rnd[3];
		bucket_owed -= db_credit;
		if (stall_left > 0)
			stall_left--;
	endtask

	initial
	begin
		seed = 32'h8e64f1b8;
		{clk, done, dg_valid, flit_out_credit, flit_in_valid, db_credit} = '0;
		dg_data = '0;
		flit_in_data = '0;
		reset = 1'b1;
		dg_tokens = fifo_depth;
		rx_tokens = fifo_depth;
		{router_owed, bucket_owed, sent, delivered, replayed, stall_left} = '0;
		stall_done = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (idle_cycles) @(posedge clk);
		while (delivered < num_words)
		begin
			@(posedge clk);
			#1;
			model_cycle();
		end
		{dg_valid, flit_out_credit, flit_in_valid, db_credit} = '0;
		done = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		$display("Errors: %0d, words sent %0d, words delivered %0d", error_count, sent, delivered);
		if (error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < cycle_limit)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Errors: %0d, words sent %0d, words delivered %0d", error_count, sent, delivered);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ns

module tb_checker (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       done,
	input  logic                       dg_valid,
	input  logic [noc_pkg::word_w-1:0] dg_data,
	input  logic                       dg_credit,
	input  logic                       flit_out_valid,
	input  logic [noc_pkg::flit_w-1:0] flit_out_data,
	input  logic                       flit_out_credit,
	input  logic                       flit_in_valid,
	input  logic [noc_pkg::flit_w-1:0] flit_in_data,
	input  logic                       flit_in_credit,
	input  logic                       db_valid,
	input  logic [noc_pkg::word_w-1:0] db_data,
	input  logic                       db_corrected,
	input  logic                       db_credit,
	output int                         error_count
);

	import noc_pkg::*;

	logic [word_w-1:0] sent_q [$];
	logic [flit_w-1:0] rx_q [$];
	int out_cnt, db_cnt, out_credits, db_credits, dg_credits, in_credits, cycle, expect_cycle;
	logic seen_input, timing_armed, finished;
	logic [word_w:0] fixed;

	// Hamming(7,4) with parity at codeword positions 1, 2 and 4
	function automatic logic [flit_w-1:0] encode_ref(input logic [word_w-1:0] word);
		logic [nibble_w-1:0] d;
		logic [cw_w-1:0] cw;
		d = word[word_w-1:addr_w];
		cw[2] = d[0];
		cw[4] = d[1];
		cw[5] = d[2];
		cw[6] = d[3];
		cw[0] = d[0] ^ d[1] ^ d[3];
		cw[1] = d[0] ^ d[2] ^ d[3];
		cw[3] = d[1] ^ d[2] ^ d[3];
		return {cw, word[addr_w-1:0]};
	endfunction

	// Nearest-codeword decode that returns the corrected flag above the word
	function automatic logic [word_w:0] correct_ref(input logic [flit_w-1:0] flit);
		logic [flit_w-1:0] cand;
		logic [word_w:0] result;
		int n;
		result = '0;
		for (n = 0; n < 16; n++)
		begin
			cand = encode_ref({n[nibble_w-1:0], flit[addr_w-1:0]});
			if ($countones(cand ^ flit) <= 1)
				result = {cand != flit, n[nibble_w-1:0], flit[addr_w-1:0]};
		end
		return result;
	endfunction

	task automatic compare(input string name, input logic [15:0] got, input logic [15:0] expected);
		if (got !== expected)
		begin
			error_count++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
		end
	endtask

	task automatic report(input string msg);
		error_count++;
		$display("ERROR: %s", msg);
	endtask

	// Sampled on the falling edge so every signal is half a cycle from its change
	always @(negedge clk)
	begin
		if (reset)
		begin
			sent_q.delete();
			rx_q.delete();
			{out_cnt, db_cnt, out_credits, db_credits, dg_credits, in_credits} = '0;
			{cycle, expect_cycle, error_count} = '0;
			{seen_input, timing_armed, finished} = '0;
		end
		else if (!finished)
		begin
			cycle++;
			if (!seen_input)
			begin
				seen_input = dg_valid || flit_in_valid || flit_out_credit || db_credit;
				if (!seen_input && (flit_out_valid || db_valid || dg_credit || flit_in_credit))
					report("a valid or credit output went high before any input was driven");
			end
			dg_credits += dg_credit;
			in_credits += flit_in_credit;
			out_credits += flit_out_credit;
			db_credits += db_credit;
			if (flit_in_valid)
				rx_q.push_back(flit_in_data);
			if (flit_out_valid)
			begin
				if (out_cnt < sent_q.size())
					compare("flit_out_data", flit_out_data, encode_ref(sent_q[out_cnt]));
				else
					report("flit_out_valid went high with no word pending");
				out_cnt++;
				if (out_cnt > router_credits + out_credits)
					report("more flits sent to the router than it gave credits for");
			end
			if (timing_armed && cycle == expect_cycle)
			begin
				if (!flit_out_valid)
					report("flit_out_valid did not follow an idle dg_valid by 2 cycles");
				timing_armed = 1'b0;
			end
			if (dg_valid)
			begin
				// An empty path with a router credit in hand gives the fixed latency
				if (!timing_armed && out_cnt == sent_q.size()
					&& router_credits - out_cnt + out_credits > 0)
				begin
					timing_armed = 1'b1;
					expect_cycle = cycle + 2;
				end
				sent_q.push_back(dg_data);
			end
			if (db_valid)
			begin
				if (db_cnt < rx_q.size())
				begin
					fixed = correct_ref(rx_q[db_cnt]);
					compare("db_data", db_data, fixed[word_w-1:0]);
					compare("db_corrected", db_corrected, fixed[word_w]);
				end
				else
					report("db_valid went high with no flit replayed");
				db_cnt++;
				if (db_cnt > bucket_credits + db_credits)
					report("more words sent to the bucket than it gave credits for");
			end
			if (done)
			begin
				finished = 1'b1;
				if (dg_credits != sent_q.size())
					report($sformatf("%0d dg credits returned for %0d words", dg_credits, sent_q.size()));
				if (in_credits != rx_q.size())
					report($sformatf("%0d router-in credits returned for %0d flits",
						in_credits, rx_q.size()));
				if (out_cnt != sent_q.size() || db_cnt != sent_q.size())
					report($sformatf("%0d words sent but %0d flits and %0d words came out",
						sent_q.size(), out_cnt, db_cnt));
			end
		end
	end

endmodule

// ==== pe_core_top.sv ====
`timescale 1ns/1ns

module pe_core_top (
	input  logic                       clk,
	input  logic                       reset,

	input  logic                       dg_valid,
	input  logic [noc_pkg::word_w-1:0] dg_data,
	output logic                       dg_credit,

	output logic                       flit_out_valid,
	output logic [noc_pkg::flit_w-1:0] flit_out_data,
	input  logic                       flit_out_credit,

	input  logic                       flit_in_valid,
	input  logic [noc_pkg::flit_w-1:0] flit_in_data,
	output logic                       flit_in_credit,

	output logic                       db_valid,
	output logic [noc_pkg::word_w-1:0] db_data,
	output logic                       db_corrected,
	input  logic                       db_credit
);

	import noc_pkg::*;

	logic dg_empty;
	logic [word_w-1:0] dg_head;
	logic dg_pop;

	logic rx_empty;
	logic [flit_w-1:0] rx_head;
	logic rx_pop;

	// Transmit path, data generator words in and encoded flits out
	credit_fifo #(
		.depth(fifo_depth),
		.width(word_w)
	) u_dg_fifo (
		.clk(clk),
		.reset(reset),
		.in_valid(dg_valid),
		.in_data(dg_data),
		.credit(dg_credit),
		.empty(dg_empty),
		.head(dg_head),
		.pop(dg_pop)
	);

	hamming_encode_stage u_encode (
		.clk(clk),
		.reset(reset),
		.empty(dg_empty),
		.head(dg_head),
		.pop(dg_pop),
		.flit_valid(flit_out_valid),
		.flit_data(flit_out_data),
		.flit_credit(flit_out_credit)
	);

	// Receive path, router flits in and corrected words out to the bucket
	credit_fifo #(
		.depth(fifo_depth),
		.width(flit_w)
	) u_rx_fifo (
		.clk(clk),
		.reset(reset),
		.in_valid(flit_in_valid),
		.in_data(flit_in_data),
		.credit(flit_in_credit),
		.empty(rx_empty),
		.head(rx_head),
		.pop(rx_pop)
	);

	hamming_correct_stage u_correct (
		.clk(clk),
		.reset(reset),
		.empty(rx_empty),
		.head(rx_head),
		.pop(rx_pop),
		.word_valid(db_valid),
		.word_data(db_data),
		.corrected(db_corrected),
		.word_credit(db_credit)
	);

endmodule

// ==== hamming_correct_stage.sv ====
`timescale 1ns/1ns

module hamming_correct_stage (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       empty,
	input  logic [noc_pkg::flit_w-1:0] head,
	output logic                       pop,
	output logic                       word_valid,
	output logic [noc_pkg::word_w-1:0] word_data,
	output logic                       corrected,
	input  logic                       word_credit
);

	import noc_pkg::*;

	logic [bucket_cnt_w-1:0] credit_cnt;
	logic [addr_w-1:0] addr;
	logic [nibble_w-1:0] nibble_fixed;
	logic [2:0] syndrome;
	hamming_cw_u rx_cw;
	hamming_cw_u fixed;

	assign addr = head[addr_w-1:0];
	assign rx_cw.raw = head[flit_w-1:addr_w];

	assign pop = !empty && (credit_cnt != '0);

	// Syndrome bit k checks every position whose index has bit k set
	assign syndrome[0] = rx_cw.raw[0] ^ rx_cw.raw[2] ^ rx_cw.raw[4] ^ rx_cw.raw[6];
	assign syndrome[1] = rx_cw.raw[1] ^ rx_cw.raw[2] ^ rx_cw.raw[5] ^ rx_cw.raw[6];
	assign syndrome[2] = rx_cw.raw[3] ^ rx_cw.raw[4] ^ rx_cw.raw[5] ^ rx_cw.raw[6];

	// A nonzero syndrome is the 1-based position of the flipped bit
	always_comb
	begin
		fixed = rx_cw;
		if (syndrome != 3'd0)
		begin
			fixed.raw[syndrome - 3'd1] = ~rx_cw.raw[syndrome - 3'd1];
		end
	end

	assign nibble_fixed = {fixed.fields.d4, fixed.fields.d3, fixed.fields.d2, fixed.fields.d1};

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			word_data <= {nibble_fixed, addr};
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			credit_cnt <= bucket_cnt_w'(bucket_credits);
			word_valid <= 1'b0;
			corrected <= 1'b0;
		end
		else
		begin
			word_valid <= pop;
			corrected <= pop && (syndrome != 3'd0);
			if (word_credit && !pop)
			begin
				credit_cnt <= credit_cnt + 1'b1;
			end
			else if (pop && !word_credit)
			begin
				credit_cnt <= credit_cnt - 1'b1;
			end
		end
	end

	// The bucket never returns more credits than it was given
	a_bucket_credit_bound: assert property (@(posedge clk) disable iff (reset)
		credit_cnt <= bucket_credits)
		else $error("hamming_correct_stage: bucket credit count above limit");

endmodule

// ==== hamming_encode_stage.sv ====
`timescale 1ns/1ns

module hamming_encode_stage (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       empty,
	input  logic [noc_pkg::word_w-1:0] head,
	output logic                       pop,
	output logic                       flit_valid,
	output logic [noc_pkg::flit_w-1:0] flit_data,
	input  logic                       flit_credit
);

	import noc_pkg::*;

	logic [router_cnt_w-1:0] credit_cnt;
	logic [addr_w-1:0] addr;
	logic [nibble_w-1:0] nibble;
	hamming_cw_u cw;

	assign addr = head[addr_w-1:0];
	assign nibble = head[word_w-1:addr_w];

	// A word leaves the FIFO only when the router has room for the flit
	assign pop = !empty && (credit_cnt != '0);

	always_comb
	begin
		cw.fields.d1 = nibble[0];
		cw.fields.d2 = nibble[1];
		cw.fields.d3 = nibble[2];
		cw.fields.d4 = nibble[3];
		// Each parity bit covers the data positions whose index has that bit set
		cw.fields.p1 = cw.fields.d1 ^ cw.fields.d2 ^ cw.fields.d4;
		cw.fields.p2 = cw.fields.d1 ^ cw.fields.d3 ^ cw.fields.d4;
		cw.fields.p3 = cw.fields.d2 ^ cw.fields.d3 ^ cw.fields.d4;
	end

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			flit_data <= {cw.raw, addr};
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			credit_cnt <= router_cnt_w'(router_credits);
			flit_valid <= 1'b0;
		end
		else
		begin
			flit_valid <= pop;
			if (flit_credit && !pop)
			begin
				credit_cnt <= credit_cnt + 1'b1;
			end
			else if (pop && !flit_credit)
			begin
				credit_cnt <= credit_cnt - 1'b1;
			end
		end
	end

	// The router never returns more credits than it was given
	a_router_credit_bound: assert property (@(posedge clk) disable iff (reset)
		credit_cnt <= router_credits)
		else $error("hamming_encode_stage: router credit count above limit");

endmodule

// ==== credit_fifo.sv ====
`timescale 1ns/1ns

module credit_fifo #(
	parameter int depth = noc_pkg::fifo_depth,
	parameter int width = noc_pkg::word_w
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             in_valid,
	input  logic [width-1:0] in_data,
	output logic             credit,
	output logic             empty,
	output logic [width-1:0] head,
	input  logic             pop
);

	logic [width-1:0] mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth)-1:0] rd_ptr;
	logic [$clog2(depth+1)-1:0] count;
	logic full;

	assign empty = (count == '0);
	assign full = (int'(count) == depth);

	// The head is visible without waiting for a clock edge
	assign head = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end
		else
		begin
			if (in_valid)
			begin
				if (int'(wr_ptr) == depth - 1)
				begin
					wr_ptr <= '0;
				end
				else
				begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (pop)
			begin
				if (int'(rd_ptr) == depth - 1)
				begin
					rd_ptr <= '0;
				end
				else
				begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			if (in_valid && !pop)
			begin
				count <= count + 1'b1;
			end
			else if (pop && !in_valid)
			begin
				count <= count - 1'b1;
			end
			// One credit goes back to the sender for every entry freed
			credit <= pop;
		end
	end

	// A sender that honours its credits can never push into a full buffer
	a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> !full)
		else $error("credit_fifo: push while full");

	a_no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
		pop |-> !empty)
		else $error("credit_fifo: pop while empty");

endmodule

// ==== noc_pkg.sv ====
package noc_pkg;

	// Flit and word field widths
	localparam int addr_w = 4;
	localparam int nibble_w = 4;
	localparam int cw_w = 7;

	// A local word carries the address in the low bits and the nibble above it
	localparam int word_w = addr_w + nibble_w;

	// A flit carries the address in bits 3..0 and the codeword in bits 10..4
	localparam int flit_w = addr_w + cw_w;

	// Each receive FIFO holds this many words, so a sender starts with as many credits
	localparam int fifo_depth = 4;

	// Initial credits toward the router and toward the data bucket
	localparam int router_credits = 4;
	localparam int bucket_credits = 2;

	// Counter widths wide enough to hold the full credit value
	localparam int router_cnt_w = $clog2(router_credits + 1);
	localparam int bucket_cnt_w = $clog2(bucket_credits + 1);

	// Hamming(7,4) codeword seen two ways.
	// The field view follows the classic layout with parity at positions 1, 2 and 4.
	// The raw view lets the corrector flip a bit by position.
	typedef union packed {
		struct packed {
			logic d4;
			logic d3;
			logic d2;
			logic p3;
			logic d1;
			logic p2;
			logic p1;
		} fields;
		logic [cw_w-1:0] raw;
	} hamming_cw_u;

endpackage
